// File: logic/sifh_settings.svh
// sizes of the SiFH peak finder
// timestamp and bin address widths, pixel, sample and acquisition counts
// width of the per-bin hit counters
`ifndef SIFH_SETTINGS_SVH
`define SIFH_SETTINGS_SVH

// timestamp width in bits
`define Np 8

// histogram bin address width, 2^Nb bins per pixel
`define Nb 4

// pixels sharing one histogram array
`define PIXEL_NUM 2

// timestamps per pixel in one acquisition
`define DATA_NUM 2

// acquisitions per pass
`define ACQ_NUM 4

// bin counter width, holds DATA_NUM * ACQ_NUM hits
`define COUNT_W 4

`endif

// File: logic/sifhPkg.sv
// shared types of the SiFH pipeline
// sample word union, pipeline stage structs, peak, window and result sets
`include "sifh_settings.svh"

package sifhPkg;

    // pixel index width, never below one bit
    localparam int PIX_W = (`PIXEL_NUM > 1) ? $clog2(`PIXEL_NUM) : 1;

    typedef logic [PIX_W-1:0] pixelIdx;

    // coarse view of a timestamp
    typedef struct packed {
        logic [`Nb-1:0]     coarseBin;
        logic [`Np-`Nb-1:0] remainder;
    } coarseSplit;

    // one timestamp word
    // raw for the fine pass, split for the coarse pass
    typedef union packed {
        logic [`Np-1:0] raw;
        coarseSplit     coarse;
    } sampleWord;

    // sequencer tag of the strobed sample
    typedef struct packed {
        pixelIdx pixel;
        logic    finePass;
        logic    firstOfPass;
        logic    lastOfPass;
    } seqTag;

    // filter to histogram stage
    typedef struct packed {
        logic           valid;
        logic           firstOfPass;
        logic           lastOfPass;
        logic           finePass;
        pixelIdx        pixel;
        logic [`Nb-1:0] bin;
    } binWrite;

    // histogram to peak stage
    typedef struct packed {
        logic                valid;
        logic                firstOfPass;
        logic                lastOfPass;
        logic                finePass;
        pixelIdx             pixel;
        logic [`Nb-1:0]      bin;
        logic [`COUNT_W-1:0] count;
    } countUpdate;

    // peak bin per pixel
    typedef struct packed {
        logic [`PIXEL_NUM-1:0][`Nb-1:0] bin;
    } peakSet;

    // fine window of one pixel
    typedef struct packed {
        logic [`Np-1:0] lo;
        logic [`Np-1:0] hi;
    } windowEntry;

    typedef struct packed {
        windowEntry [`PIXEL_NUM-1:0] entry;
    } windowSet;

    // absolute peak timestamp per pixel
    typedef struct packed {
        logic [`PIXEL_NUM-1:0][`Np-1:0] value;
    } resultSet;

endpackage

// File: logic/passSequencer.sv
// sample sequencer of the SiFH peak finder
// sample, pixel and acquisition counters
// pass bit and pass start and end flags of the strobed sample
`include "sifh_settings.svh"

module passSequencer (
    input  logic           clk,
    input  logic           combin_res,
    input  logic           wrEn,
    output sifhPkg::seqTag tag,
    output logic           finePass
);

    import sifhPkg::*;

    localparam int sampleW = (`DATA_NUM > 1) ? $clog2(`DATA_NUM) : 1;
    localparam int acqW    = (`ACQ_NUM > 1) ? $clog2(`ACQ_NUM) : 1;

    logic [sampleW-1:0] sampleCnt;
    pixelIdx            pixelCnt;
    logic [acqW-1:0]    acqCnt;
    logic               sampleWrap;
    logic               pixelWrap;
    logic               acqWrap;

    // ************************************************************
    // wrap points of the three counters
    // ************************************************************
    assign sampleWrap = (sampleCnt == sampleW'(`DATA_NUM - 1));
    assign pixelWrap  = (pixelCnt == PIX_W'(`PIXEL_NUM - 1));
    assign acqWrap    = (acqCnt == acqW'(`ACQ_NUM - 1));

    // tag of the sample strobed this cycle
    assign tag.pixel       = pixelCnt;
    assign tag.finePass    = finePass;
    assign tag.firstOfPass = (sampleCnt == '0) && (pixelCnt == '0) && (acqCnt == '0);
    assign tag.lastOfPass  = sampleWrap && pixelWrap && acqWrap;

    // ************************************************************
    // counters, advanced once per strobe
    // ************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            finePass  <= 1'b0;
        end else if (wrEn) begin
            if (sampleWrap) begin
                sampleCnt <= '0;
                if (pixelWrap) begin
                    pixelCnt <= '0;
                    if (acqWrap) begin
                        // pass complete, swap coarse and fine
                        acqCnt   <= '0;
                        finePass <= ~finePass;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/sampleFilter.sv
// input stage of the SiFH pipeline
// coarse bin selection, fine window test and offset removal
`include "sifh_settings.svh"

module sampleFilter (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    input  sifhPkg::sampleWord data,
    input  sifhPkg::seqTag     tag,
    input  sifhPkg::windowSet  windows,
    output sifhPkg::binWrite   binOut
);

    import sifhPkg::*;

    windowEntry     pixWindow;
    logic           inWindow;
    logic [`Np-1:0] offset;
    binWrite        binNext;

    // window of the pixel being delivered
    assign pixWindow = windows.entry[tag.pixel];
    assign inWindow  = (data.raw >= pixWindow.lo) && (data.raw <= pixWindow.hi);
    // distance above delta, fits in Nb bits inside the window
    assign offset    = data.raw - pixWindow.lo;

    always_comb begin
        binNext = '0;
        if (wrEn) begin
            // flags travel even when the sample is dropped
            binNext.firstOfPass = tag.firstOfPass;
            binNext.lastOfPass  = tag.lastOfPass;
            binNext.finePass    = tag.finePass;
            binNext.pixel       = tag.pixel;
            if (tag.finePass) begin
                binNext.valid = inWindow;
                binNext.bin   = offset[`Nb-1:0];
            end else begin
                // top bits of the timestamp
                binNext.valid = 1'b1;
                binNext.bin   = data.coarse.coarseBin;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binOut <= '0;
        end else begin
            binOut <= binNext;
        end
    end

endmodule

// File: logic/histogramBins.sv
// histogram stage of the SiFH pipeline
// per-pixel bin counters with valid bits
// single-cycle read-modify-write, whole array invalidated at pass start
`include "sifh_settings.svh"

module histogramBins (
    input  logic                clk,
    input  logic                combin_res,
    input  sifhPkg::binWrite    binIn,
    output sifhPkg::countUpdate countOut
);

    import sifhPkg::*;

    localparam int binNum = 1 << `Nb;

    logic [`COUNT_W-1:0]               binCount [`PIXEL_NUM][binNum];
    logic [`PIXEL_NUM-1:0][binNum-1:0] binValid;
    logic                              hitValid;
    logic [`COUNT_W-1:0]               newCount;
    countUpdate                        countNext;

    // ************************************************************
    // read side
    // ************************************************************
    // stale bins and pass start both read as empty
    assign hitValid = binValid[binIn.pixel][binIn.bin] && !binIn.firstOfPass;
    assign newCount = (hitValid ? binCount[binIn.pixel][binIn.bin] : '0) + 1'b1;

    always_comb begin
        countNext.valid       = binIn.valid;
        countNext.firstOfPass = binIn.firstOfPass;
        countNext.lastOfPass  = binIn.lastOfPass;
        countNext.finePass    = binIn.finePass;
        countNext.pixel       = binIn.pixel;
        countNext.bin         = binIn.bin;
        // dropped samples forward no count
        countNext.count       = binIn.valid ? newCount : '0;
    end

    // ************************************************************
    // write side
    // ************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            countOut <= '0;
        end else begin
            if (binIn.firstOfPass) begin
                binValid <= '0;
            end
            // own bit set after the sweep, last write wins
            if (binIn.valid) begin
                binValid[binIn.pixel][binIn.bin] <= 1'b1;
            end
            countOut <= countNext;
        end
    end

    // counter storage
    always_ff @(posedge clk) begin
        if (binIn.valid) begin
            binCount[binIn.pixel][binIn.bin] <= newCount;
        end
    end

endmodule

// File: logic/peakTracker.sv
// peak stage of the SiFH pipeline
// running maximum and its bin per pixel, snapshot at pass end
`include "sifh_settings.svh"

module peakTracker (
    input  logic                clk,
    input  logic                combin_res,
    input  sifhPkg::countUpdate countIn,
    output sifhPkg::peakSet     peaks,
    output logic                snapshot,
    output logic                snapshotFine
);

    import sifhPkg::*;

    logic [`COUNT_W-1:0] maxCount [`PIXEL_NUM];
    logic [`Nb-1:0]      maxBin [`PIXEL_NUM];
    logic [`COUNT_W-1:0] nextCount [`PIXEL_NUM];
    logic [`Nb-1:0]      nextBin [`PIXEL_NUM];

    // compare against restarted maxima on the first item of a pass
    always_comb begin
        for (int i = 0; i < `PIXEL_NUM; i++) begin
            nextCount[i] = countIn.firstOfPass ? '0 : maxCount[i];
            nextBin[i]   = countIn.firstOfPass ? '0 : maxBin[i];
            // strictly greater, earlier bin keeps a tie
            if (countIn.valid && (countIn.pixel == PIX_W'(i)) &&
                (countIn.count > nextCount[i])) begin
                nextCount[i] = countIn.count;
                nextBin[i]   = countIn.bin;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < `PIXEL_NUM; i++) begin
                maxCount[i] <= '0;
                maxBin[i]   <= '0;
            end
            snapshot     <= 1'b0;
            snapshotFine <= 1'b0;
        end else begin
            for (int i = 0; i < `PIXEL_NUM; i++) begin
                maxCount[i] <= nextCount[i];
                maxBin[i]   <= nextBin[i];
            end
            // one-cycle pulse after the last sample of a pass
            snapshot     <= countIn.lastOfPass;
            snapshotFine <= countIn.lastOfPass && countIn.finePass;
        end
    end

    // published peaks, includes the last item's update
    always_ff @(posedge clk) begin
        if (countIn.lastOfPass) begin
            for (int i = 0; i < `PIXEL_NUM; i++) begin
                peaks.bin[i] <= nextBin[i];
            end
        end
    end

endmodule

// File: logic/windowCalc.sv
// window placement and result stage of the SiFH pipeline
// clamped fine windows from coarse peaks, absolute result from fine peaks
`include "sifh_settings.svh"

module windowCalc (
    input  logic              clk,
    input  logic              combin_res,
    input  sifhPkg::peakSet   peaks,
    input  logic              snapshot,
    input  logic              snapshotFine,
    output sifhPkg::windowSet windows,
    output sifhPkg::resultSet result,
    output logic              resultStrobe
);

    import sifhPkg::*;

    // window width, half width and highest allowed lower bound
    localparam int binSpan  = 1 << `Nb;
    localparam int sbOffset = binSpan / 2;
    localparam int topLo    = (1 << `Np) - binSpan;

    // window around a coarse peak, held inside the timestamp range
    function automatic windowEntry placeWindow(input logic [`Nb-1:0] peakBin);
        windowEntry w;
        int         ch;
        int         lo;
        int         hi;
        // coarse peak back on the timestamp scale
        ch = int'(peakBin) << (`Np - `Nb);
        if (ch <= sbOffset) begin
            lo = 0;
        end else if (ch + sbOffset > topLo) begin
            lo = topLo;
        end else begin
            lo = ch - sbOffset;
        end
        hi = lo + binSpan - 1;
        w.lo = lo[`Np-1:0];
        w.hi = hi[`Np-1:0];
        return w;
    endfunction

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windows      <= '0;
            result       <= '0;
            resultStrobe <= 1'b0;
        end else begin
            resultStrobe <= snapshot && snapshotFine;
            for (int i = 0; i < `PIXEL_NUM; i++) begin
                if (snapshot && !snapshotFine) begin
                    windows.entry[i] <= placeWindow(peaks.bin[i]);
                end
                // fine peak plus delta
                if (snapshot && snapshotFine) begin
                    result.value[i] <= windows.entry[i].lo + peaks.bin[i];
                end
            end
        end
    end

endmodule

// File: logic/sifhTop.sv
// top level of the two-pass SiFH peak finder
// sequencer, filter, histogram, peak and window stages in a chain
module sifhTop (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    input  sifhPkg::sampleWord data,
    output sifhPkg::resultSet  result,
    output logic               resultStrobe,
    output logic               finePass
);

    import sifhPkg::*;

    seqTag      tag;
    binWrite    binStage;
    countUpdate countStage;
    peakSet     peaks;
    logic       snapshot;
    logic       snapshotFine;
    windowSet   windows;

    // ************************************************************
    // sample path
    // ************************************************************
    passSequencer i_seq (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .tag        (tag),
        .finePass   (finePass)
    );

    // windows fed back from the last stage
    sampleFilter i_filter (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .data       (data),
        .tag        (tag),
        .windows    (windows),
        .binOut     (binStage)
    );

    histogramBins i_hist (
        .clk        (clk),
        .combin_res (combin_res),
        .binIn      (binStage),
        .countOut   (countStage)
    );

    // ************************************************************
    // peak and result path
    // ************************************************************
    peakTracker i_peak (
        .clk          (clk),
        .combin_res   (combin_res),
        .countIn      (countStage),
        .peaks        (peaks),
        .snapshot     (snapshot),
        .snapshotFine (snapshotFine)
    );

    windowCalc i_window (
        .clk          (clk),
        .combin_res   (combin_res),
        .peaks        (peaks),
        .snapshot     (snapshot),
        .snapshotFine (snapshotFine),
        .windows      (windows),
        .result       (result),
        .resultStrobe (resultStrobe)
    );

endmodule

// File: verification/sifhTb.sv
// testbench of the two-pass SiFH peak finder
// clock and reset, golden-file stimulus with random idle gaps
// result and pass-bit checks, strobe monitor, watchdog
`include "sifh_settings.svh"

module sifhTb;

    import sifhPkg::*;

    localparam int frameNum       = 3;
    localparam int slotNum        = `PIXEL_NUM * `DATA_NUM;
    localparam int samplesPerPass = `ACQ_NUM * slotNum;
    localparam int maxGap         = 3;
    // idle cycles needed between coarse and fine pass
    localparam int passGap        = 3;
    // filter, histogram, peak snapshot, result register
    localparam int strobeDelay    = 4;
    localparam int runLimit       = (frameNum * 2 * samplesPerPass * (maxGap + 1) + 50) * 20;

    logic      clk;
    logic      combin_res;
    logic      wrEn;
    sampleWord data;
    resultSet  result;
    logic      resultStrobe;
    logic      finePass;

    // golden stimulus per frame, pass, acquisition and slot
    logic [`Np-1:0] stimMem [frameNum][2][`ACQ_NUM][slotNum];
    logic [`Np-1:0] expMem [frameNum][`PIXEL_NUM];

    // cycle at which each pending result is due, and its frame
    int dueCycle[$];
    int dueFrame[$];

    int cycleCnt = 0;
    int errorCount;
    int checkCount;
    int strobeCount;
    int seed;
    bit loaded;

    sifhTop i_dut (
        .clk          (clk),
        .combin_res   (combin_res),
        .wrEn         (wrEn),
        .data         (data),
        .result       (result),
        .resultStrobe (resultStrobe),
        .finePass     (finePass)
    );

    // ************************************************************
    // clock, cycle count, watchdog
    // ************************************************************
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    initial begin
        #(runLimit);
        $display("timeout: run still busy after %0d time units", runLimit);
        $display("Finished with errors");
        $finish;
    end

    // ************************************************************
    // helpers
    // ************************************************************
    task automatic logError(input string msg);
        errorCount++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    function automatic int randomGap();
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % (maxGap + 1);
    endfunction

    // next line that is neither blank nor a comment
    task automatic nextDataLine(input int fd, output string line, output bit found);
        int  n;
        bit  done;
        found = 1'b0;
        done  = 1'b0;
        while (!done) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                done = 1'b1;
            end else if (line[0] != "#" && line[0] != "\n" && line[0] != "\r") begin
                found = 1'b1;
                done  = 1'b1;
            end
        end
    endtask

    // four slots per line, two pixels of two samples
    task automatic loadGolden(output bit ok);
        int             fd;
        int             n;
        string          line;
        bit             found;
        logic [`Np-1:0] v0;
        logic [`Np-1:0] v1;
        logic [`Np-1:0] v2;
        logic [`Np-1:0] v3;
        ok = 1'b1;
        fd = $fopen("verification/sifh_golden.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            for (int f = 0; f < frameNum; f++) begin
                for (int p = 0; p < 2; p++) begin
                    for (int a = 0; a < `ACQ_NUM; a++) begin
                        nextDataLine(fd, line, found);
                        n = found ? $sscanf(line, "%h %h %h %h", v0, v1, v2, v3) : 0;
                        if (n != 4) begin
                            ok = 1'b0;
                        end
                        stimMem[f][p][a][0] = v0;
                        stimMem[f][p][a][1] = v1;
                        stimMem[f][p][a][2] = v2;
                        stimMem[f][p][a][3] = v3;
                    end
                end
                // expected line, one result per pixel
                nextDataLine(fd, line, found);
                n = found ? $sscanf(line, "%h %h", v0, v1) : 0;
                if (n != 2) begin
                    ok = 1'b0;
                end
                expMem[f][0] = v0;
                expMem[f][1] = v1;
            end
            $fclose(fd);
        end
    endtask

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic idleCycle(input bit fine);
        @(negedge clk);
        checkCount++;
        if (finePass !== fine) begin
            logError($sformatf("finePass %b while idle, expected %b", finePass, fine));
        end
        wrEn     = 1'b0;
        data.raw = '0;
    endtask

    task automatic runPass(input int frame, input bit fine);
        int gap;
        for (int a = 0; a < `ACQ_NUM; a++) begin
            for (int s = 0; s < slotNum; s++) begin
                gap = randomGap();
                if (a == 0 && s == 0) begin
                    // room for the window update before the fine pass
                    if (fine && gap < passGap) begin
                        gap = passGap;
                    end
                    // later frames start right after the previous one
                    if (!fine && frame > 0) begin
                        gap = 0;
                    end
                end
                repeat (gap) idleCycle(fine);
                @(negedge clk);
                checkCount++;
                if (finePass !== fine) begin
                    logError($sformatf("finePass %b at frame %0d sample %0d, expected %b",
                        finePass, frame, a * slotNum + s, fine));
                end
                wrEn     = 1'b1;
                data.raw = stimMem[frame][fine][a][s];
                if (fine && a == `ACQ_NUM - 1 && s == slotNum - 1) begin
                    dueCycle.push_back(cycleCnt + strobeDelay);
                    dueFrame.push_back(frame);
                end
            end
        end
    endtask

    // ************************************************************
    // result monitor
    // ************************************************************
    initial begin
        wait (combin_res === 1'b1);
        forever begin
            @(negedge clk);
            if (dueCycle.size() > 0 && dueCycle[0] < cycleCnt) begin
                logError($sformatf("no resultStrobe for frame %0d", dueFrame[0] + 1));
                void'(dueCycle.pop_front());
                void'(dueFrame.pop_front());
            end
            checkCount++;
            if (resultStrobe === 1'b1) begin
                if (dueCycle.size() == 0 || dueCycle[0] != cycleCnt) begin
                    logError($sformatf("resultStrobe at cycle %0d not expected", cycleCnt));
                end else begin
                    for (int p = 0; p < `PIXEL_NUM; p++) begin
                        checkCount++;
                        if (result.value[p] !== expMem[dueFrame[0]][p]) begin
                            logError($sformatf("frame %0d pixel %0d result %02h, expected %02h",
                                dueFrame[0] + 1, p, result.value[p], expMem[dueFrame[0]][p]));
                        end
                    end
                    strobeCount++;
                    void'(dueCycle.pop_front());
                    void'(dueFrame.pop_front());
                end
            end else if (resultStrobe !== 1'b0) begin
                logError($sformatf("resultStrobe is %b", resultStrobe));
            end else if (strobeCount == 0 && result !== '0) begin
                // nothing published yet
                logError($sformatf("result %h before the first frame ended", result));
            end
        end
    end

    // ************************************************************
    // main sequence
    // ************************************************************
    initial begin
        errorCount  = 0;
        checkCount  = 0;
        strobeCount = 0;
        seed        = 32'h8ff9;
        combin_res  = 1'b0;
        wrEn        = 1'b0;
        data        = '0;
        loadGolden(loaded);
        if (loaded) begin
            // three rising edges in reset, release on the falling edge after
            repeat (3) @(posedge clk);
            @(negedge clk);
            combin_res = 1'b1;
            for (int f = 0; f < frameNum; f++) begin
                runPass(f, 1'b0);
                runPass(f, 1'b1);
            end
            // let the last result through, then watch for stray strobes
            while (dueCycle.size() > 0) begin
                idleCycle(1'b0);
            end
            repeat (6) idleCycle(1'b0);
            checkCount++;
            if (strobeCount != frameNum) begin
                logError($sformatf("%0d results seen, expected %0d", strobeCount, frameNum));
            end
        end else begin
            errorCount++;
            $display("golden file verification/sifh_golden.txt missing or malformed");
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+logic
logic/sifhPkg.sv
logic/passSequencer.sv
logic/sampleFilter.sv
logic/histogramBins.sv
logic/peakTracker.sv
logic/windowCalc.sv
logic/sifhTop.sv
verification/sifhTb.sv

// File: verification/sifh_golden.txt
# per frame: 4 coarse then 4 fine acquisition lines, hex: p0 s0, p0 s1, p1 s0, p1 s1
# then one expected line, hex: result of pixel 0, result of pixel 1
# frame 1, pixel 0 coarse peak in bin 0, low clamp
03 05 72 75
04 12 73 71
05 07 75 3A
90 05 75 76
05 05 72 72
20 05 60 72
06 05 78 6A
0E 1F 72 71
05 72
# frame 2, pixel 0 coarse peak in bin 15, high clamp
F2 55 E1 E5
F8 57 E9 2C
FE 31 E3 D0
12 44 E0 7F
FA FA E4 E4
EF FB E8 D8
FA F0 E4 D7
C0 FA E4 E6
FA E4
# frame 3, mid-range windows, stale bins of frame 2 would change pixel 1
80 85 10 1F
8F 40 15 18
81 8A 33 1A
40 13 02 19
82 7C 14 0B
82 90 0B 14
82 77 07 0B
88 7C 18 12
82 0B
